// File: src/audio_macros.svh
// Shared width and code constants for the audio path.
// Sample width and accumulator width must differ by exactly one bit.

`ifndef AUDIO_MACROS_SVH
`define AUDIO_MACROS_SVH

// Audio sample and mixer accumulator widths
`define AUD_SAMPLE_W 16
`define AUD_ACC_W    17

// Left and right, cross-linked in pairs
`define AUD_CHANNELS 2

// Host command port word width
`define IO_DATA_W 16

// Host command selecting the volume attenuation
`define CMD_VOL_ATT 8'h26

// clk cycles per half bit-clock, at most 16
`define I2S_HALF_DIV 2

`endif

// File: src/audio_pkg.sv
// Types shared by the audio mixer RTL and its testbench.
// Widths come from audio_macros.svh.

`include "audio_macros.svh"

package audio_pkg;

	// Raw audio sample as carried on ports
	typedef logic [`AUD_SAMPLE_W-1:0] sample_t;

	// One bit of headroom for the mixer arithmetic
	typedef logic signed [`AUD_ACC_W-1:0] acc_t;

	// Host command port word
	typedef logic [`IO_DATA_W-1:0] io_word_t;

	// Bit 4 mutes, bits 3..0 give the right shift
	typedef logic [4:0] att_t;

	// Stereo width modes
	typedef enum logic [1:0] {
		MIX_NONE = 2'd0,
		MIX_LOW  = 2'd1,
		MIX_MID  = 2'd2,
		MIX_FULL = 2'd3
	} mix_mode_t;

	typedef enum logic {
		CMD_IDLE = 1'b0,
		CMD_DATA = 1'b1
	} cmd_state_t;

endpackage

// File: src/hps_cmd_decoder.sv
// Host command decoder; only the volume command is acted on, all others are ignored.
// i_io_din must be stable from the rising strobe until the strobe falls.

`timescale 1ns/1ps

`include "audio_macros.svh"

module hps_cmd_decoder (
	input  logic                clk,
	input  logic                resetd,
	input  logic                i_io_uio,
	input  logic                i_io_strobe,
	input  audio_pkg::io_word_t i_io_din,
	output logic                o_io_ack,
	output audio_pkg::att_t     o_vol_att
);

	////////////////////////////////////////////////////////////////////////////
	// Strobe edge and acknowledge
	////////////////////////////////////////////////////////////////////////////

	logic strobe_d;
	logic strobe_rise;

	// One word per rising strobe level
	assign strobe_rise = i_io_strobe & ~strobe_d;

	// Acknowledge is the strobe level seen through two registers
	always_ff @(posedge clk) begin
		if (resetd) begin
			strobe_d <= 1'b0;
			o_io_ack <= 1'b0;
		end else begin
			strobe_d <= i_io_strobe;
			o_io_ack <= strobe_d;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Command and data tracking
	////////////////////////////////////////////////////////////////////////////

	audio_pkg::cmd_state_t state;
	logic [7:0]            cmd_q;

	always_ff @(posedge clk) begin
		if (resetd) begin
			state     <= audio_pkg::CMD_IDLE;
			cmd_q     <= 8'h00;
			o_vol_att <= '0;
		end else if (!i_io_uio) begin
			// Deselect ends the current command
			state <= audio_pkg::CMD_IDLE;
			cmd_q <= 8'h00;
		end else if (strobe_rise) begin
			case (state)
				audio_pkg::CMD_IDLE: begin
					// First word after select is the command
					cmd_q <= i_io_din[7:0];
					state <= audio_pkg::CMD_DATA;
				end
				audio_pkg::CMD_DATA: begin
					if (cmd_q == `CMD_VOL_ATT) begin
						o_vol_att <= audio_pkg::att_t'(i_io_din[4:0]);
					end
				end
				default: begin
					state <= audio_pkg::CMD_IDLE;
				end
			endcase
		end
	end

endmodule

// File: src/aud_mix_channel.sv
// One mixer channel: deglitch, convert, add host audio, cross-mix, attenuate, clamp.
// i_pre comes from the partner channel's o_pre and lags this channel by one cycle.

`timescale 1ns/1ps

`include "audio_macros.svh"

module aud_mix_channel (
	input  logic                 clk,
	input  logic                 resetd,
	input  audio_pkg::sample_t   i_core,
	input  audio_pkg::sample_t   i_host,
	input  logic                 i_signed,
	input  audio_pkg::mix_mode_t i_mix,
	input  audio_pkg::att_t      i_att,
	input  audio_pkg::sample_t   i_pre,
	output audio_pkg::sample_t   o_pre,
	output audio_pkg::sample_t   o_sample
);

	audio_pkg::sample_t core_d1;
	audio_pkg::sample_t core_d2;
	audio_pkg::sample_t core_acc;

	audio_pkg::acc_t conv;
	audio_pkg::acc_t host_ext;
	audio_pkg::acc_t pre_ext;
	audio_pkg::acc_t mix_sum;
	audio_pkg::acc_t a2;
	audio_pkg::acc_t a3;
	audio_pkg::acc_t a4;

	logic sat;

	////////////////////////////////////////////////////////////////////////////
	// Deglitch
	////////////////////////////////////////////////////////////////////////////

	// Core value accepted only after two stages agree
	always_ff @(posedge clk) begin
		if (resetd) begin
			core_d1  <= '0;
			core_d2  <= '0;
			core_acc <= '0;
		end else begin
			core_d1 <= i_core;
			core_d2 <= core_d1;
			if (core_d1 == core_d2) begin
				core_acc <= core_d2;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Conversion and cross-mix terms
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		// Unsigned input loses its LSB to stay positive in 17 bits
		if (i_signed) begin
			conv = {core_acc[`AUD_SAMPLE_W-1], core_acc};
		end else begin
			conv = {2'b00, core_acc[`AUD_SAMPLE_W-1:1]};
		end

		host_ext = {i_host[`AUD_SAMPLE_W-1], i_host};
		pre_ext  = {i_pre[`AUD_SAMPLE_W-1], i_pre};

		case (i_mix)
			audio_pkg::MIX_NONE: mix_sum = a2;
			audio_pkg::MIX_LOW:  mix_sum = a2 - (a2 >>> 3) + (pre_ext >>> 2);
			audio_pkg::MIX_MID:  mix_sum = a2 - (a2 >>> 2) + (pre_ext >>> 1);
			audio_pkg::MIX_FULL: mix_sum = (a2 >>> 1) + pre_ext;
			default:             mix_sum = a2;
		endcase
	end

	// Top two bits disagree when the result leaves 16-bit range
	assign sat = a4[`AUD_ACC_W-1] ^ a4[`AUD_ACC_W-2];

	////////////////////////////////////////////////////////////////////////////
	// Arithmetic pipeline
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (resetd) begin
			a2       <= '0;
			a3       <= '0;
			a4       <= '0;
			o_pre    <= '0;
			o_sample <= '0;
		end else begin
			// Stage 1 host add
			a2 <= conv + host_ext;

			// Stage 2 stereo width, half-scale link to the partner
			a3    <= mix_sum;
			o_pre <= a2[`AUD_ACC_W-1:1];

			// Stage 3 volume
			if (i_att[4]) begin
				a4 <= '0;
			end else begin
				a4 <= a3 >>> i_att[3:0];
			end

			// Stage 4 clamp
			if (sat) begin
				o_sample <= {a4[`AUD_ACC_W-1], {(`AUD_SAMPLE_W-1){a4[`AUD_ACC_W-2]}}};
			end else begin
				o_sample <= a4[`AUD_SAMPLE_W-1:0];
			end
		end
	end

endmodule

// File: src/i2s_serializer.sv
// I2S transmitter, 32-bit frame with 16-bit left then right, MSB one bit after lrclk.
// Samples are taken once per frame with no handshake.

`timescale 1ns/1ps

`include "audio_macros.svh"

module i2s_serializer (
	input  logic               clk,
	input  logic               resetd,
	input  audio_pkg::sample_t i_left,
	input  audio_pkg::sample_t i_right,
	output logic               o_i2s_bclk,
	output logic               o_i2s_lrclk,
	output logic               o_i2s_data
);

	logic [3:0]                  div_cnt;
	logic                        div_end;
	logic                        bclk_fall;
	logic [4:0]                  bit_cnt;
	logic [4:0]                  bit_nxt;
	logic [2*`AUD_SAMPLE_W-1:0]  shreg;

	////////////////////////////////////////////////////////////////////////////
	// Bit clock
	////////////////////////////////////////////////////////////////////////////

	assign div_end   = (div_cnt == 4'(`I2S_HALF_DIV - 1));
	assign bclk_fall = div_end & o_i2s_bclk;

	always_ff @(posedge clk) begin
		if (resetd) begin
			div_cnt    <= 4'd0;
			o_i2s_bclk <= 1'b0;
		end else if (div_end) begin
			div_cnt    <= 4'd0;
			o_i2s_bclk <= ~o_i2s_bclk;
		end else begin
			div_cnt <= div_cnt + 4'd1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Frame and shift register
	////////////////////////////////////////////////////////////////////////////

	// Slot number after the coming falling edge
	assign bit_nxt = bit_cnt + 5'd1;

	// Starts at the last slot so the first edge opens a frame
	always_ff @(posedge clk) begin
		if (resetd) begin
			bit_cnt     <= 5'd31;
			o_i2s_lrclk <= 1'b0;
			o_i2s_data  <= 1'b0;
		end else if (bclk_fall) begin
			bit_cnt     <= bit_nxt;
			o_i2s_lrclk <= bit_nxt[4];
			o_i2s_data  <= shreg[2*`AUD_SAMPLE_W-1];
		end
	end

	// Load at frame start, the old MSB still goes out on that edge
	always_ff @(posedge clk) begin
		if (resetd) begin
			shreg <= '0;
		end else if (bclk_fall) begin
			if (bit_nxt == 5'd0) begin
				shreg <= {i_left, i_right};
			end else begin
				shreg <= shreg << 1;
			end
		end
	end

endmodule

// File: src/audio_top.sv
// Audio path top: host volume command, two cross-linked mixer channels, I2S out.
// The cross link pairs channel k with channel 1-k, so exactly two channels.

`timescale 1ns/1ps

`include "audio_macros.svh"

module audio_top (
	input  logic                 clk,
	input  logic                 resetd,
	input  logic                 i_io_uio,
	input  logic                 i_io_strobe,
	input  audio_pkg::io_word_t  i_io_din,
	input  audio_pkg::sample_t   i_core_l,
	input  audio_pkg::sample_t   i_core_r,
	input  audio_pkg::sample_t   i_host_l,
	input  audio_pkg::sample_t   i_host_r,
	input  logic                 i_audio_signed,
	input  audio_pkg::mix_mode_t i_audio_mix,
	output logic                 o_io_ack,
	output logic                 o_i2s_bclk,
	output logic                 o_i2s_lrclk,
	output logic                 o_i2s_data
);

	audio_pkg::att_t    vol_att;
	audio_pkg::sample_t core_in  [`AUD_CHANNELS];
	audio_pkg::sample_t host_in  [`AUD_CHANNELS];
	audio_pkg::sample_t pre_link [`AUD_CHANNELS];
	audio_pkg::sample_t mix_out  [`AUD_CHANNELS];

	////////////////////////////////////////////////////////////////////////////
	// Host command port
	////////////////////////////////////////////////////////////////////////////

	hps_cmd_decoder u_cmd (
		.clk         (clk),
		.resetd      (resetd),
		.i_io_uio    (i_io_uio),
		.i_io_strobe (i_io_strobe),
		.i_io_din    (i_io_din),
		.o_io_ack    (o_io_ack),
		.o_vol_att   (vol_att)
	);

	////////////////////////////////////////////////////////////////////////////
	// Mixer channels
	////////////////////////////////////////////////////////////////////////////

	// Index 0 is left, 1 is right
	assign core_in[0] = i_core_l;
	assign core_in[1] = i_core_r;
	assign host_in[0] = i_host_l;
	assign host_in[1] = i_host_r;

	for (genvar ch = 0; ch < `AUD_CHANNELS; ch++) begin : g_chan
		aud_mix_channel u_mix (
			.clk      (clk),
			.resetd   (resetd),
			.i_core   (core_in[ch]),
			.i_host   (host_in[ch]),
			.i_signed (i_audio_signed),
			.i_mix    (i_audio_mix),
			.i_att    (vol_att),
			.i_pre    (pre_link[`AUD_CHANNELS-1-ch]),
			.o_pre    (pre_link[ch]),
			.o_sample (mix_out[ch])
		);
	end

	////////////////////////////////////////////////////////////////////////////
	// I2S output
	////////////////////////////////////////////////////////////////////////////

	i2s_serializer u_i2s (
		.clk         (clk),
		.resetd      (resetd),
		.i_left      (mix_out[0]),
		.i_right     (mix_out[1]),
		.o_i2s_bclk  (o_i2s_bclk),
		.o_i2s_lrclk (o_i2s_lrclk),
		.o_i2s_data  (o_i2s_data)
	);

endmodule

// File: tests/tb_audio_tasks.svh
// Host port, checking, mixer model and directed tests for tb_audio_top.
// Included inside the testbench module and uses its signals and counters.

`ifndef TB_AUDIO_TASKS_SVH
`define TB_AUDIO_TASKS_SVH

task automatic check_value(input string name, input logic [15:0] got,
		input logic [15:0] exp);
	check_cnt++;
	if (got !== exp) begin
		err_cnt++;
		$display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
	end
endtask

// Ack must follow the strobe level within a few cycles
task automatic wait_for_ack(input logic level);
	int n;
	n = 0;
	@(posedge clk);
	while (o_io_ack !== level && n < 16) begin
		@(posedge clk);
		n++;
	end
	check_cnt++;
	if (o_io_ack !== level) begin
		err_cnt++;
		$display("Acknowledge did not follow the strobe to %0b within 16 cycles", level);
	end
endtask

task automatic host_write(input audio_pkg::io_word_t word);
	@(posedge clk);
	i_io_din    <= word;
	i_io_strobe <= 1'b1;
	wait_for_ack(1'b1);
	@(posedge clk);
	i_io_strobe <= 1'b0;
	wait_for_ack(1'b0);
	@(posedge clk);
endtask

task automatic set_volume(input audio_pkg::att_t att);
	@(posedge clk);
	i_io_uio <= 1'b1;
	host_write({8'h00, `CMD_VOL_ATT});
	host_write({11'h000, att});
	@(posedge clk);
	i_io_uio <= 1'b0;
	cur_att = att;
endtask

task automatic drive_inputs(input audio_pkg::sample_t core_l,
		input audio_pkg::sample_t core_r, input audio_pkg::sample_t host_l,
		input audio_pkg::sample_t host_r, input logic sgn,
		input audio_pkg::mix_mode_t mode);
	@(posedge clk);
	i_core_l       <= core_l;
	i_core_r       <= core_r;
	i_host_l       <= host_l;
	i_host_r       <= host_r;
	i_audio_signed <= sgn;
	i_audio_mix    <= mode;
endtask

task automatic wait_frames(input int n);
	int start_cnt;
	start_cnt = frame_cnt;
	while (frame_cnt < start_cnt + n) begin
		@(posedge clk);
	end
endtask

// Converted core sample plus host sample, in 17-bit range
function automatic int model_a2(input audio_pkg::sample_t core,
		input audio_pkg::sample_t host, input logic sgn);
	int a1;
	if (sgn)
		a1 = int'($signed(core));
	else
		a1 = int'(core >> 1);
	return a1 + int'($signed(host));
endfunction

// Partner's pre value is its own A2 halved, so no iteration is needed
function automatic audio_pkg::sample_t model_out(input int a2, input int partner_a2,
		input audio_pkg::mix_mode_t mode, input audio_pkg::att_t att);
	int pre_in;
	int a3;
	int a4;
	pre_in = partner_a2 >>> 1;
	case (mode)
		audio_pkg::MIX_LOW:  a3 = a2 - (a2 >>> 3) + (pre_in >>> 2);
		audio_pkg::MIX_MID:  a3 = a2 - (a2 >>> 2) + (pre_in >>> 1);
		audio_pkg::MIX_FULL: a3 = (a2 >>> 1) + pre_in;
		default:             a3 = a2;
	endcase
	if (att[4])
		a4 = 0;
	else
		a4 = a3 >>> att[3:0];
	if (a4 > 32767)
		a4 = 32767;
	else if (a4 < -32768)
		a4 = -32768;
	return audio_pkg::sample_t'(a4);
endfunction

task automatic compare_frame(input string what);
	int a2_l;
	int a2_r;
	a2_l = model_a2(i_core_l, i_host_l, i_audio_signed);
	a2_r = model_a2(i_core_r, i_host_r, i_audio_signed);
	check_value({"i2s left, ", what}, frame_l, model_out(a2_l, a2_r, i_audio_mix, cur_att));
	check_value({"i2s right, ", what}, frame_r, model_out(a2_r, a2_l, i_audio_mix, cur_att));
endtask

// Settle, then the second full frame is loaded after the change
task automatic check_output(input string what);
	repeat (20) @(posedge clk);
	wait_frames(2);
	compare_frame(what);
endtask

////////////////////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////////////////////

task automatic test_reset();
	wait_frames(2);
	check_value("i2s left after reset", frame_l, 16'h0000);
	check_value("i2s right after reset", frame_r, 16'h0000);
	check_value("o_io_ack after reset", {15'h0000, o_io_ack}, 16'h0000);
endtask

task automatic test_conversion();
	int    k;
	logic  sgn;
	string label;
	sgn = 1'b0;
	repeat (2) begin
		label = sgn ? "signed" : "unsigned";
		for (k = 0; k < 4; k++) begin
			drive_inputs(audio_pkg::sample_t'($urandom()), audio_pkg::sample_t'($urandom()),
				audio_pkg::sample_t'($urandom()), audio_pkg::sample_t'($urandom()),
				sgn, audio_pkg::MIX_NONE);
			check_output(label);
		end
		sgn = 1'b1;
	end
endtask

task automatic test_crossmix();
	audio_pkg::mix_mode_t mode;
	mode = audio_pkg::MIX_LOW;
	repeat (3) begin
		drive_inputs(audio_pkg::sample_t'($urandom()), audio_pkg::sample_t'($urandom()),
			audio_pkg::sample_t'($urandom()), audio_pkg::sample_t'($urandom()), 1'b1, mode);
		check_output($sformatf("mix %0d random", mode));
		drive_inputs(16'h7FFF, 16'h8000, 16'h7FFF, 16'h8000, 1'b1, mode);
		check_output($sformatf("mix %0d opposite extremes", mode));
		drive_inputs(16'h7FFF, 16'h7FFF, 16'h7FFF, 16'h7FFF, 1'b1, mode);
		check_output($sformatf("mix %0d positive extremes", mode));
		drive_inputs(16'h8000, 16'h8000, 16'h8000, 16'h8000, 1'b1, mode);
		check_output($sformatf("mix %0d negative extremes", mode));
		mode = audio_pkg::mix_mode_t'(mode + 1);
	end
endtask

task automatic test_volume();
	// Large opposite samples keep a shift of 15 nonzero
	drive_inputs(16'h7000, 16'h9000, 16'h6000, 16'hA000, 1'b1, audio_pkg::MIX_LOW);
	set_volume(5'd3);
	check_output("volume 3");
	set_volume(5'd15);
	check_output("volume 15");
	set_volume(5'd16);
	check_output("mute");
	check_value("i2s left, mute", frame_l, 16'h0000);
	check_value("i2s right, mute", frame_r, 16'h0000);
endtask

task automatic test_filtering();
	set_volume(5'd1);
	check_output("volume 1");
	// New select cycle, volume code as the first word is only the command
	@(posedge clk);
	i_io_uio <= 1'b1;
	host_write({8'h00, `CMD_VOL_ATT});
	@(posedge clk);
	i_io_uio <= 1'b0;
	// Volume command and data without select
	host_write({8'h00, `CMD_VOL_ATT});
	host_write(16'h0009);
	// Other command, its data must not load
	@(posedge clk);
	i_io_uio <= 1'b1;
	host_write(16'h0025);
	host_write(16'h0007);
	@(posedge clk);
	i_io_uio <= 1'b0;
	check_output("after ignored writes");
endtask

task automatic test_glitch();
	int start_cnt;
	drive_inputs(16'h1234, 16'hE000, 16'h0100, 16'h0000, 1'b1, audio_pkg::MIX_MID);
	check_output("glitch base");
	// Back to back single-cycle excursions over two whole frames
	start_cnt = frame_cnt;
	while (frame_cnt < start_cnt + 2) begin
		@(posedge clk);
		i_core_l <= 16'h6ABC;
		@(posedge clk);
		i_core_l <= 16'h1234;
	end
	@(posedge clk);
	compare_frame("during glitches");
	drive_inputs(16'h6ABC, 16'hE000, 16'h0100, 16'h0000, 1'b1, audio_pkg::MIX_MID);
	check_output("steady change");
endtask

`endif

// File: tests/tb_audio_top.sv
// Directed testbench for audio_top, host command port in and I2S frames out.
// Outputs are compared one I2S frame at a time, after the mixer has settled.

`timescale 1ns/1ps

`include "audio_macros.svh"

module tb_audio_top;

	// About twice the length of the test sequence
	localparam int CYCLE_LIMIT = 20000;
	localparam int CLK_PERIOD  = 10;

	logic                 clk = 1'b0;
	logic                 resetd;
	logic                 i_io_uio;
	logic                 i_io_strobe;
	audio_pkg::io_word_t  i_io_din;
	audio_pkg::sample_t   i_core_l;
	audio_pkg::sample_t   i_core_r;
	audio_pkg::sample_t   i_host_l;
	audio_pkg::sample_t   i_host_r;
	logic                 i_audio_signed;
	audio_pkg::mix_mode_t i_audio_mix;
	logic                 o_io_ack;
	logic                 o_i2s_bclk;
	logic                 o_i2s_lrclk;
	logic                 o_i2s_data;

	// Attenuation the decoder is expected to hold
	audio_pkg::att_t cur_att = '0;

	int err_cnt   = 0;
	int check_cnt = 0;
	int cycle_cnt = 0;

	// I2S receiver state
	audio_pkg::sample_t cap_sh      = '0;
	audio_pkg::sample_t cap_left    = '0;
	logic               cap_lr_prev = 1'b0;
	audio_pkg::sample_t frame_l     = '0;
	audio_pkg::sample_t frame_r     = '0;
	int                 frame_cnt   = 0;
	time                bclk_rise_t = 0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	audio_top i_audio_top (
		.clk            (clk),
		.resetd         (resetd),
		.i_io_uio       (i_io_uio),
		.i_io_strobe    (i_io_strobe),
		.i_io_din       (i_io_din),
		.i_core_l       (i_core_l),
		.i_core_r       (i_core_r),
		.i_host_l       (i_host_l),
		.i_host_r       (i_host_r),
		.i_audio_signed (i_audio_signed),
		.i_audio_mix    (i_audio_mix),
		.o_io_ack       (o_io_ack),
		.o_i2s_bclk     (o_i2s_bclk),
		.o_i2s_lrclk    (o_i2s_lrclk),
		.o_i2s_data     (o_i2s_data)
	);

	////////////////////////////////////////////////////////////////////////////
	// Frame capture
	////////////////////////////////////////////////////////////////////////////

	// The bit in the slot where lrclk changes is the LSB of the previous word
	// Bit clock period is 2 * I2S_HALF_DIV clk cycles
	always @(posedge o_i2s_bclk) begin : capture
		audio_pkg::sample_t word;
		if (bclk_rise_t != 0) begin
			check_value("o_i2s_bclk period in ns", 16'($time - bclk_rise_t),
				16'(2 * `I2S_HALF_DIV * CLK_PERIOD));
		end
		bclk_rise_t = $time;
		word = {cap_sh[14:0], o_i2s_data};
		cap_sh      <= word;
		cap_lr_prev <= o_i2s_lrclk;
		if (o_i2s_lrclk != cap_lr_prev) begin
			if (!cap_lr_prev) begin
				cap_left <= word;
			end else begin
				frame_l   <= cap_left;
				frame_r   <= word;
				frame_cnt <= frame_cnt + 1;
			end
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("Timeout: tests still running after %0d cycles", CYCLE_LIMIT);
			$display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
			$display("TEST FAILED");
			$finish;
		end
	end

	`include "tb_audio_tasks.svh"

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		void'($urandom(32'h867fa5a4));
		resetd         = 1'b1;
		i_io_uio       = 1'b0;
		i_io_strobe    = 1'b0;
		i_io_din       = '0;
		i_core_l       = '0;
		i_core_r       = '0;
		i_host_l       = '0;
		i_host_r       = '0;
		i_audio_signed = 1'b0;
		i_audio_mix    = audio_pkg::MIX_NONE;
		repeat (8) @(posedge clk);
		resetd <= 1'b0;

		test_reset();
		test_conversion();
		test_crossmix();
		test_volume();
		test_filtering();
		test_glitch();

		$display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

// File: project.f
+incdir+src
+incdir+tests
src/audio_pkg.sv
src/hps_cmd_decoder.sv
src/aud_mix_channel.sv
src/i2s_serializer.sv
src/audio_top.sv
tests/tb_audio_top.sv
